// File: Bender.yml
package:
  name: branch_predictor

sources:
  - include_dirs:
      - source
    files:
      - source/bp_pkg.sv
      - source/pattern_table.sv
      - source/branch_predictor.sv
      - source/predict_stats.sv
      - source/bp_top.sv
      - target: test
        files:
          - tb/bp_tb.sv

// File: all.f
+incdir+source
source/bp_pkg.sv
source/pattern_table.sv
source/branch_predictor.sv
source/predict_stats.sv
source/bp_top.sv
tb/bp_tb.sv

// File: source/bp_consts.svh
`ifndef BP_CONSTS_SVH
`define BP_CONSTS_SVH

// Number of entries in the tagged pattern table.
`define BP_TABLE_SIZE 256

// Low address bits that select a table entry.
`define BP_INDEX_W 8

// Upper address bits stored as the tag.
`define BP_TAG_W 56

// Instruction address width seen by the fetch stage.
`define BP_ADDR_W 64

// Two bit saturating direction counter.
`define BP_CNT_W 2

// Width of the statistics counters.
`define BP_STAT_W 32

`endif

// File: source/bp_pkg.sv
`default_nettype none

`include "bp_consts.svh"

package bp_pkg;

	typedef logic [`BP_ADDR_W-1:0] bp_addr_t;
	typedef logic [`BP_INDEX_W-1:0] bp_index_t;
	typedef logic [`BP_TAG_W-1:0] bp_tag_t;
	typedef logic [`BP_STAT_W-1:0] bp_stat_t;

	// The upper bit of the counter is the predicted direction.
	typedef enum logic [`BP_CNT_W-1:0] {
		CNT_STRONG_NT = 2'd0,
		CNT_WEAK_NT   = 2'd1,
		CNT_WEAK_T    = 2'd2,
		CNT_STRONG_T  = 2'd3
	} bp_cnt_t;

endpackage

`default_nettype wire

// File: source/bp_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_consts.svh"

module bp_top
	import bp_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     branch_valid,
	input  bp_addr_t branch_addr,
	input  logic     resolve_taken,
	output logic     prediction,
	output logic     ready,
	output bp_stat_t branch_count,
	output bp_stat_t mispredict_count
);

	bp_index_t rd_index;
	bp_tag_t   rd_tag;
	bp_cnt_t   rd_cnt;
	logic      wr_en;
	bp_index_t wr_index;
	bp_tag_t   wr_tag;
	bp_cnt_t   wr_cnt;
	logic      resolve_valid;
	logic      resolve_pred;
	logic      resolve_taken_out;

	pattern_table u_table (
		.clk      (clk),
		.reset    (reset),
		.rd_index (rd_index),
		.rd_tag   (rd_tag),
		.rd_cnt   (rd_cnt),
		.wr_en    (wr_en),
		.wr_index (wr_index),
		.wr_tag   (wr_tag),
		.wr_cnt   (wr_cnt),
		.ready    (ready)
	);

	branch_predictor u_predictor (
		.clk               (clk),
		.reset             (reset),
		.branch_valid      (branch_valid),
		.branch_addr       (branch_addr),
		.resolve_taken     (resolve_taken),
		.ready             (ready),
		.prediction        (prediction),
		.rd_index          (rd_index),
		.rd_tag            (rd_tag),
		.rd_cnt            (rd_cnt),
		.wr_en             (wr_en),
		.wr_index          (wr_index),
		.wr_tag            (wr_tag),
		.wr_cnt            (wr_cnt),
		.resolve_valid     (resolve_valid),
		.resolve_pred      (resolve_pred),
		.resolve_taken_out (resolve_taken_out)
	);

	predict_stats u_stats (
		.clk              (clk),
		.reset            (reset),
		.resolve_valid    (resolve_valid),
		.resolve_pred     (resolve_pred),
		.resolve_taken    (resolve_taken_out),
		.branch_count     (branch_count),
		.mispredict_count (mispredict_count)
	);

endmodule

`default_nettype wire

// File: source/branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_consts.svh"

module branch_predictor
	import bp_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  logic      branch_valid,
	input  bp_addr_t  branch_addr,
	input  logic      resolve_taken,
	input  logic      ready,
	output logic      prediction,
	output bp_index_t rd_index,
	input  bp_tag_t   rd_tag,
	input  bp_cnt_t   rd_cnt,
	output logic      wr_en,
	output bp_index_t wr_index,
	output bp_tag_t   wr_tag,
	output bp_cnt_t   wr_cnt,
	output logic      resolve_valid,
	output logic      resolve_pred,
	output logic      resolve_taken_out
);

	bp_tag_t  lookup_tag;
	logic     lookup_hit;
	logic     accept;

	logic     pend_valid;
	bp_addr_t pend_addr;
	logic     pend_hit;
	bp_cnt_t  pend_cnt;
	logic     pend_pred;

	// Index from the low bits, tag from everything above them.
	assign rd_index   = branch_addr[`BP_INDEX_W-1:0];
	assign lookup_tag = branch_addr[`BP_ADDR_W-1 -: `BP_TAG_W];
	assign lookup_hit = (rd_tag == lookup_tag);

	assign prediction = ready && lookup_hit && rd_cnt[`BP_CNT_W-1];
	assign accept     = branch_valid && ready;

	// Snapshot of the lookup, held for the resolve cycle.
	always_ff @(posedge clk) begin
		if (reset) begin
			pend_valid <= 1'b0;
		end else begin
			pend_valid <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pend_addr <= branch_addr;
			pend_hit  <= lookup_hit;
			pend_cnt  <= rd_cnt;
			pend_pred <= prediction;
		end
	end

	// On a hit the counter steps toward the outcome and saturates.
	// On a miss the entry is taken over by the new tag.
	always_comb begin
		if (pend_hit) begin
			if (resolve_taken && (pend_cnt != CNT_STRONG_T)) begin
				wr_cnt = bp_cnt_t'(pend_cnt + 1'b1);
			end else if (!resolve_taken && (pend_cnt != CNT_STRONG_NT)) begin
				wr_cnt = bp_cnt_t'(pend_cnt - 1'b1);
			end else begin
				wr_cnt = pend_cnt;
			end
		end else begin
			wr_cnt = resolve_taken ? CNT_WEAK_T : CNT_WEAK_NT;
		end
	end

	assign wr_en    = pend_valid;
	assign wr_index = pend_addr[`BP_INDEX_W-1:0];
	assign wr_tag   = pend_addr[`BP_ADDR_W-1 -: `BP_TAG_W];

	assign resolve_valid     = pend_valid;
	assign resolve_pred      = pend_pred;
	assign resolve_taken_out = resolve_taken;

	a_no_lookup_before_ready: assert property (
		@(posedge clk) disable iff (reset)
		!ready |-> !branch_valid
	) else $error("branch_predictor: branch_valid high while table not ready");

	// Every table update belongs to a lookup taken one cycle earlier.
	a_write_follows_lookup: assert property (
		@(posedge clk) disable iff (reset)
		wr_en |-> $past(branch_valid && ready)
	) else $error("branch_predictor: update without an accepted lookup");

endmodule

`default_nettype wire

// File: source/pattern_table.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_consts.svh"

module pattern_table
	import bp_pkg::*;
(
	input  logic      clk,
	input  logic      reset,
	input  bp_index_t rd_index,
	output bp_tag_t   rd_tag,
	output bp_cnt_t   rd_cnt,
	input  logic      wr_en,
	input  bp_index_t wr_index,
	input  bp_tag_t   wr_tag,
	input  bp_cnt_t   wr_cnt,
	output logic      ready
);

	typedef enum logic {
		CLEARING,
		RUNNING
	} clear_state_t;

	clear_state_t state;
	bp_index_t    clr_index;

	bp_tag_t tag_mem [`BP_TABLE_SIZE];
	bp_cnt_t cnt_mem [`BP_TABLE_SIZE];

	// The sweep visits every index once, one entry per cycle, starting
	// at the first edge after reset is released.
	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= CLEARING;
			clr_index <= '0;
		end else begin
			case (state)
				CLEARING: begin
					clr_index <= clr_index + 1'b1;
					if (clr_index == bp_index_t'(`BP_TABLE_SIZE - 1)) begin
						state <= RUNNING;
					end
				end
				RUNNING: begin
					state <= RUNNING;
				end
				default: begin
					state <= CLEARING;
				end
			endcase
		end
	end

	// Storage write port. While the sweep runs it owns the write port,
	// so every entry comes back as tag zero, weakly taken.
	always_ff @(posedge clk) begin
		if (state == CLEARING) begin
			tag_mem[clr_index] <= '0;
			cnt_mem[clr_index] <= CNT_WEAK_T;
		end else if (wr_en) begin
			tag_mem[wr_index] <= wr_tag;
			cnt_mem[wr_index] <= wr_cnt;
		end
	end

	// Combinational read. A write in the same cycle is seen only
	// after the edge, so lookups get the older contents.
	assign rd_tag = tag_mem[rd_index];
	assign rd_cnt = cnt_mem[rd_index];

	assign ready = (state == RUNNING);

	// The predictor must hold off updates until the table is usable.
	a_no_write_in_sweep: assert property (
		@(posedge clk) disable iff (reset)
		(state == CLEARING) |-> !wr_en
	) else $error("pattern_table: write request during clear sweep");

endmodule

`default_nettype wire

// File: source/predict_stats.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_consts.svh"

module predict_stats
	import bp_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  logic     resolve_valid,
	input  logic     resolve_pred,
	input  logic     resolve_taken,
	output bp_stat_t branch_count,
	output bp_stat_t mispredict_count
);

	logic mispredict;

	// A branch is mispredicted when the guess and the outcome differ.
	assign mispredict = resolve_valid && (resolve_pred != resolve_taken);

	// Both counts wrap around at full width.
	always_ff @(posedge clk) begin
		if (reset) begin
			branch_count <= '0;
		end else if (resolve_valid) begin
			branch_count <= branch_count + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mispredict_count <= '0;
		end else if (mispredict) begin
			mispredict_count <= mispredict_count + 1'b1;
		end
	end

	// A resolved branch must carry a known guess and outcome.
	a_resolve_known: assert property (
		@(posedge clk) disable iff (reset)
		resolve_valid |-> !$isunknown({resolve_pred, resolve_taken})
	) else $error("predict_stats: unknown prediction or outcome on a resolved branch");

endmodule

`default_nettype wire

// File: tb/bp_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "bp_consts.svh"

module bp_tb
	import bp_pkg::*;
();

	typedef struct {
		int       test;
		bp_addr_t addr;
		logic     taken;
		logic     valid;
		int       rep;
		int       gap;
		int       exp_pred;
	} stim_t;

	logic     clk = 1'b0;
	logic     reset;
	logic     branch_valid;
	bp_addr_t branch_addr;
	logic     resolve_taken;
	logic     prediction;
	logic     ready;
	bp_stat_t branch_count;
	bp_stat_t mispredict_count;

	stim_t    stim_q[$];
	bp_tag_t  m_tag [`BP_TABLE_SIZE];
	logic [`BP_CNT_W-1:0] m_cnt [`BP_TABLE_SIZE];
	logic     m_pend_valid, m_pend_taken, m_pend_pred, m_pend_hit;
	bp_addr_t m_pend_addr;
	logic [`BP_CNT_W-1:0] m_pend_cnt;
	bp_stat_t m_branches, m_misses;
	int       checks = 0, errors = 0, test_checks = 0, test_errors = 0;
	bp_index_t idx_pool [4] = '{8'h10, 8'h11, 8'h20, 8'h30};
	bp_tag_t   tag_pool [4] = '{56'h0, 56'h1, 56'h11, 56'hABCDE};

	always #2 clk = ~clk;

	bp_top u_dut (
		.clk              (clk),
		.reset            (reset),
		.branch_valid     (branch_valid),
		.branch_addr      (branch_addr),
		.resolve_taken    (resolve_taken),
		.prediction       (prediction),
		.ready            (ready),
		.branch_count     (branch_count),
		.mispredict_count (mispredict_count)
	);

	task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		checks++;
		test_checks++;
		if (actual !== expected) begin
			errors++;
			test_errors++;
			$display("FAILED at %0t: %s: got %0h, expected %0h", $time, what, actual, expected);
		end
	endtask

	task automatic add_entry(input int test, input bp_addr_t addr, input logic taken,
			input logic valid, input int rep, input int gap, input int exp_pred);
		stim_t entry;
		entry = '{test, addr, taken, valid, rep, gap, exp_pred};
		stim_q.push_back(entry);
	endtask

	// A freshly cleared table holds tag zero and weakly taken everywhere.
	task automatic model_reset();
		foreach (m_tag[i]) begin
			m_tag[i] = '0;
			m_cnt[i] = 2'd2;
		end
		m_pend_valid = 1'b0;
		m_pend_taken = 1'b0;
		m_branches = '0;
		m_misses = '0;
	endtask

	// The update works from the entry as it was seen at lookup time.
	task automatic model_update();
		bp_index_t idx;
		idx = m_pend_addr[`BP_INDEX_W-1:0];
		m_tag[idx] = m_pend_addr[`BP_ADDR_W-1:`BP_INDEX_W];
		if (!m_pend_hit) begin
			m_cnt[idx] = m_pend_taken ? 2'd2 : 2'd1;
		end else if (m_pend_taken) begin
			m_cnt[idx] = (m_pend_cnt == 2'd3) ? 2'd3 : m_pend_cnt + 1'b1;
		end else begin
			m_cnt[idx] = (m_pend_cnt == 2'd0) ? 2'd0 : m_pend_cnt - 1'b1;
		end
		m_branches++;
		if (m_pend_pred != m_pend_taken) begin
			m_misses++;
		end
	endtask

	// One clock cycle, entered and left at a falling edge.
	task automatic drive_cycle(input bp_addr_t addr, input logic taken, input logic valid,
			input int exp_pred);
		bp_index_t idx;
		logic hit, model_pred;
		logic [`BP_CNT_W-1:0] cnt;
		idx = addr[`BP_INDEX_W-1:0];
		branch_valid = valid;
		branch_addr = addr;
		resolve_taken = m_pend_taken;
		#1;
		hit = (m_tag[idx] == addr[`BP_ADDR_W-1:`BP_INDEX_W]);
		cnt = m_cnt[idx];
		model_pred = hit && cnt[`BP_CNT_W-1];
		if (valid) begin
			check_value(prediction, model_pred, $sformatf("prediction for %h vs model", addr));
			if (exp_pred != 2) begin
				check_value(prediction, exp_pred[0], $sformatf("prediction for %h", addr));
			end
		end
		@(posedge clk);
		if (m_pend_valid) begin
			model_update();
		end
		m_pend_valid = valid;
		m_pend_addr = addr;
		m_pend_taken = taken;
		m_pend_pred = model_pred;
		m_pend_hit = hit;
		m_pend_cnt = cnt;
		@(negedge clk);
	endtask

	// Counts the falling edges until ready is seen high.
	task automatic wait_ready(output int cycles);
		cycles = 0;
		while (!ready) begin
			@(negedge clk);
			cycles++;
			if (cycles > 300) begin
				$display("Timeout: ready still low %0d cycles after reset", cycles);
				$display("Testbench failed");
				$finish;
			end
		end
	endtask

	task automatic apply_reset();
		int sweep_cycles;
		reset = 1'b1;
		branch_valid = 1'b0;
		repeat (5) @(negedge clk);
		check_value(ready, 1'b0, "ready during reset");
		check_value(prediction, 1'b0, "prediction during reset");
		check_value(branch_count, '0, "branch_count after reset");
		check_value(mispredict_count, '0, "mispredict_count after reset");
		reset = 1'b0;
		model_reset();
		wait_ready(sweep_cycles);
		// The sweep writes one entry per cycle, so ready rises after a full table.
		check_value(sweep_cycles, `BP_TABLE_SIZE, "clear sweep length");
	endtask

	task automatic run_test(input int id, input int label, input string name);
		foreach (stim_q[i]) begin
			if (stim_q[i].test == id) begin
				repeat (stim_q[i].rep) begin
					drive_cycle(stim_q[i].addr, stim_q[i].taken, stim_q[i].valid,
						stim_q[i].exp_pred);
					repeat (stim_q[i].gap) drive_cycle(stim_q[i].addr, 1'b0, 1'b0, 2);
				end
			end
		end
		// One idle cycle lets the last branch resolve before the counts are read.
		drive_cycle('0, 1'b0, 1'b0, 2);
		check_value(branch_count, m_branches, "branch_count");
		check_value(mispredict_count, m_misses, "mispredict_count");
		$display("Test %0d %s: %0d checks, %0d errors", label, name, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		void'($urandom(41571));
		reset = 1'b1;
		branch_valid = 1'b0;
		branch_addr = '0;
		resolve_taken = 1'b0;
		// Index 0x10 is shared by tag 0 and tag 0x11 so that they alias.
		add_entry(1, 64'h10, 1'b1, 1'b1, 1, 1, 1);
		add_entry(1, 64'h0100_0020, 1'b0, 1'b1, 1, 1, 0);
		add_entry(2, 64'h10, 1'b0, 1'b1, 2, 1, 1);
		add_entry(2, 64'h10, 1'b0, 1'b1, 2, 1, 0);
		add_entry(2, 64'h10, 1'b1, 1'b1, 2, 1, 0);
		add_entry(2, 64'h10, 1'b1, 1'b1, 2, 1, 1);
		add_entry(2, 64'h10, 1'b0, 1'b1, 1, 1, 1);
		add_entry(3, 64'h1110, 1'b1, 1'b1, 1, 1, 0);
		add_entry(3, 64'h1110, 1'b0, 1'b1, 1, 1, 1);
		add_entry(3, 64'h10, 1'b0, 1'b1, 1, 1, 0);
		add_entry(3, 64'h10, 1'b1, 1'b1, 1, 1, 0);
		add_entry(3, 64'h1110, 1'b0, 1'b1, 1, 1, 0);
		add_entry(3, 64'h1110, 1'b1, 1'b1, 1, 1, 0);
		add_entry(3, 64'h1110, 1'b1, 1'b1, 1, 1, 1);
		add_entry(4, 64'h30, 1'b0, 1'b1, 2, 0, 1);
		add_entry(4, 64'h30, 1'b0, 1'b1, 1, 1, 0);
		add_entry(4, 64'h30, 1'b1, 1'b1, 1, 1, 0);
		for (int i = 0; i < 160; i++) begin
			add_entry(5, {tag_pool[$urandom % 4], idx_pool[$urandom % 4]}, 1'($urandom % 2),
				($urandom % 8) != 0, 1, $urandom % 2, 2);
		end
		apply_reset();
		run_test(1, 1, "reset and clear");
		run_test(2, 2, "hysteresis");
		run_test(3, 3, "replacement");
		run_test(4, 4, "read before write");
		run_test(5, 5, "random stream");
		apply_reset();
		run_test(1, 6, "reset in mid-run");
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
